/* src.f */
+incdir+.
icache_pkg.sv
prefetch_ctrl.sv
cache_store.sv
miss_queue.sv
icache.sv
mem_model.sv
icache_tb.sv

/* icache_tb.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tb;

    localparam int MEM_LATENCY = 1;
    localparam int NUM_JUMPS   = 10;
    localparam int SEQ_WORDS   = 16;
    localparam int NUM_HOPS    = 40;
    localparam int NUM_TESTS   = NUM_JUMPS * SEQ_WORDS + 3 + NUM_HOPS + 1;
    localparam int TIMEOUT     = NUM_TESTS * (MEM_LATENCY + 20) * 2;

    logic                      clock;
    logic                      reset;
    logic [`ICACHE_XLEN-1:0]   proc_addr;
    logic [`ICACHE_XLEN-1:0]   proc_data;
    logic                      proc_valid;
    icache_pkg::bus_command_e  mem_command;
    logic [`ICACHE_XLEN-1:0]   mem_addr;
    logic [3:0]                mem_response;
    logic [3:0]                mem_tag;
    logic [63:0]               mem_data;

    int                        errors;
    int                        checks;
    int                        cycles;
    logic                      checking;
    logic                      skip_window;    // jump cycle still shows the old stream
    logic                      victim_watch;
    logic [`ICACHE_XLEN-1:0]   win_lo;
    logic [`ICACHE_XLEN-1:0]   victim_a;
    logic [`ICACHE_XLEN-1:0]   a;
    logic [`ICACHE_XLEN-1:0]   b;

    icache dut (
        .clock        (clock),
        .reset        (reset),
        .proc_addr    (proc_addr),
        .proc_data    (proc_data),
        .proc_valid   (proc_valid),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data)
    );

    mem_model #(.LATENCY(MEM_LATENCY)) u_mem_model (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data)
    );

    function automatic logic [`ICACHE_XLEN-1:0] mem_word(input logic [`ICACHE_XLEN-1:0] addr);
        return {addr[`ICACHE_XLEN-1:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [`ICACHE_XLEN-1:0] random_addr();
        return $urandom & 32'h0fff_fffc;   // stays clear of address wrap
    endfunction

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // compare process, sampled mid cycle
    always @(negedge clock) begin
        if (checking) begin
            if (proc_valid) begin
                checks++;
                assert (proc_data == mem_word(proc_addr)) else begin
                    errors++;
                    $display("ERROR proc_data at %h: got %h expected %h",
                             proc_addr, proc_data, mem_word(proc_addr));
                end
            end
            if (skip_window) begin
                skip_window = 1'b0;
            end else if (mem_command == icache_pkg::BUS_LOAD) begin
                checks++;
                assert ((mem_addr[2:0] == 3'b000) && (mem_addr >= win_lo) &&
                        (mem_addr <= {proc_addr[`ICACHE_XLEN-1:3], 3'b000} + 56)) else begin
                    errors++;
                    $display("ERROR mem_addr %h outside window %h, fetch %h",
                             mem_addr, win_lo, proc_addr);
                end
            end
            if (victim_watch && (mem_command == icache_pkg::BUS_LOAD)) begin
                assert (mem_addr[`ICACHE_XLEN-1:3] != victim_a[`ICACHE_XLEN-1:3]) else begin
                    errors++;
                    $display("ERROR mem_addr %h reloads a block held in the victim cache",
                             mem_addr);
                end
            end
        end
    end

    task automatic jump_to(input logic [`ICACHE_XLEN-1:0] addr);
        @(posedge clock);
        #1;
        proc_addr   = addr;
        win_lo      = {addr[`ICACHE_XLEN-1:3], 3'b000};
        skip_window = 1'b1;
    endtask

    task automatic step_to(input logic [`ICACHE_XLEN-1:0] addr);
        @(posedge clock);
        #1;
        proc_addr = addr;
    endtask

    // returns in the first cycle with proc_valid, or at the limit
    task automatic wait_valid(input int limit, input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (!proc_valid && (n < limit)) begin
            @(negedge clock);
            n++;
        end
        assert (proc_valid) else begin
            errors++;
            $display("%s: no valid data within %0d cycles at address %h", what, limit, proc_addr);
        end
    endtask

    initial begin
        void'($urandom(32'haa37_be1e));
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        checking     = 1'b0;
        skip_window  = 1'b0;
        victim_watch = 1'b0;
        win_lo       = '0;
        victim_a     = '0;
        reset        = 1'b1;
        proc_addr    = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        assert (!proc_valid && (mem_command == icache_pkg::BUS_NONE)) else begin
            errors++;
            $display("ERROR after reset proc_valid %h mem_command %h", proc_valid, mem_command);
        end
        checking = 1'b1;

        // miss, then sequential fetch through the prefetched blocks
        for (int j = 0; j < NUM_JUMPS; j++) begin
            a = random_addr();
            jump_to(a);
            wait_valid(MEM_LATENCY + 20, "miss after jump");
            for (int i = 1; i < SEQ_WORDS; i++) begin
                step_to(a + 4 * i);
                wait_valid(MEM_LATENCY + 4, "sequential fetch");
            end
        end

        // same index, other tag, then back
        a = random_addr();
        b = a ^ 32'h0000_0100;
        jump_to(a);
        wait_valid(MEM_LATENCY + 20, "victim setup A");
        jump_to(b);
        wait_valid(MEM_LATENCY + 20, "victim setup B");
        jump_to(a);
        victim_a     = a;
        victim_watch = 1'b1;
        @(negedge clock);
        assert (proc_valid) else begin
            errors++;
            $display("return to %h missed the victim cache", a);
        end
        repeat (3) @(negedge clock);
        victim_watch = 1'b0;

        // random redirects, compare process checks every valid cycle
        for (int h = 0; h < NUM_HOPS; h++) begin
            jump_to(random_addr());
            repeat ($urandom_range(1, 4)) @(posedge clock);
        end
        jump_to(random_addr());
        wait_valid(MEM_LATENCY + 20, "final miss");

        @(posedge clock);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* mem_model.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module mem_model #(
    parameter int LATENCY = 1
) (
    input  logic                      clock,
    input  logic                      reset,
    input  icache_pkg::bus_command_e  mem_command,
    input  logic [`ICACHE_XLEN-1:0]   mem_addr,
    output logic [3:0]                mem_response,
    output logic [3:0]                mem_tag,
    output logic [63:0]               mem_data
);

    logic [3:0]              next_tag;   // cycles 1 to 15, zero is never handed out
    longint                  cycle;
    logic [`ICACHE_XLEN-1:0] pend_addr [$];
    logic [3:0]              pend_tag [$];
    longint                  pend_due [$];

    // two words of a block, each word holds its address xor a fixed pattern
    function automatic logic [63:0] block_data(input logic [`ICACHE_XLEN-1:0] addr);
        logic [`ICACHE_XLEN-1:0] base;
        base = {addr[`ICACHE_XLEN-1:3], 3'b000};
        return {(base + 4) ^ 32'h5a5a_0000, base ^ 32'h5a5a_0000};
    endfunction

    // accepts every load in the same cycle
    assign mem_response = (mem_command == icache_pkg::BUS_LOAD) ? next_tag : 4'h0;

    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'h1;
            cycle    <= 0;
            mem_tag  <= 4'h0;
            mem_data <= '0;
            pend_addr.delete();
            pend_tag.delete();
            pend_due.delete();
        end else begin
            cycle   <= cycle + 1;
            mem_tag <= 4'h0;
            if (mem_response != 4'h0) begin
                pend_addr.push_back(mem_addr);
                pend_tag.push_back(mem_response);
                pend_due.push_back(cycle + LATENCY);
                next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end
            // one return per cycle, oldest first
            if ((pend_due.size() > 0) && (pend_due[0] <= cycle)) begin
                mem_tag  <= pend_tag[0];
                mem_data <= block_data(pend_addr[0]);
                void'(pend_addr.pop_front());
                void'(pend_tag.pop_front());
                void'(pend_due.pop_front());
            end
        end
    end

endmodule

/* icache.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [`ICACHE_XLEN-1:0]   proc_addr,
    output logic [`ICACHE_XLEN-1:0]   proc_data,
    output logic                      proc_valid,
    output icache_pkg::bus_command_e  mem_command,
    output logic [`ICACHE_XLEN-1:0]   mem_addr,
    input  logic [3:0]                mem_response,
    input  logic [3:0]                mem_tag,
    input  logic [63:0]               mem_data
);

    icache_pkg::probe_t  probe;
    icache_pkg::fill_t   fill;
    logic                redirect;
    logic                fetch_hit;
    logic                probe_hit;

    assign proc_valid = fetch_hit;

    prefetch_ctrl u_prefetch_ctrl (
        .clock     (clock),
        .reset     (reset),
        .proc_addr (proc_addr),
        .fetch_hit (fetch_hit),
        .probe     (probe),
        .redirect  (redirect)
    );

    cache_store u_cache_store (
        .clock     (clock),
        .reset     (reset),
        .proc_addr (proc_addr),
        .probe     (probe),
        .fill      (fill),
        .proc_data (proc_data),
        .fetch_hit (fetch_hit),
        .probe_hit (probe_hit)
    );

    miss_queue u_miss_queue (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .probe        (probe),
        .probe_hit    (probe_hit),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .fill         (fill)
    );

endmodule

/* miss_queue.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module miss_queue (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      redirect,
    input  icache_pkg::probe_t        probe,
    input  logic                      probe_hit,
    input  logic [3:0]                mem_response,
    input  logic [3:0]                mem_tag,
    input  logic [63:0]               mem_data,
    output icache_pkg::bus_command_e  mem_command,
    output logic [`ICACHE_XLEN-1:0]   mem_addr,
    output icache_pkg::fill_t         fill
);

    icache_pkg::send_entry_t       buffer [`ICACHE_SEND_SIZE];
    logic [`ICACHE_SEND_LEN-1:0]   tail_ptr;
    logic [`ICACHE_SEND_LEN-1:0]   send_ptr;
    logic [`ICACHE_SEND_LEN-1:0]   head_ptr;   // oldest entry, retired once done
    logic                          tail_free;
    logic                          enqueue;
    logic                          accept;
    logic [`ICACHE_SEND_SIZE-1:0]  match;

    assign tail_free = !buffer[tail_ptr].valid || buffer[tail_ptr].done;
    assign enqueue   = probe.valid && !probe_hit && tail_free;   // lost when tail is busy

    assign mem_command = (buffer[send_ptr].valid && !buffer[send_ptr].done &&
                          (buffer[send_ptr].mem_tag == 4'h0)) ?
                         icache_pkg::BUS_LOAD : icache_pkg::BUS_NONE;
    assign mem_addr    = buffer[send_ptr].addr;
    assign accept      = (mem_command == icache_pkg::BUS_LOAD) && (mem_response != 4'h0);

    // returning block, matched by tag against pending entries
    always_comb begin
        fill = '0;
        for (int i = 0; i < `ICACHE_SEND_SIZE; i++) begin
            match[i] = buffer[i].valid && !buffer[i].done && (mem_tag != 4'h0) &&
                       (buffer[i].mem_tag == mem_tag);
            if (match[i]) begin
                fill.valid = 1'b1;
                fill.addr  = buffer[i].addr;
                fill.data  = mem_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || redirect) begin
            for (int i = 0; i < `ICACHE_SEND_SIZE; i++) begin
                buffer[i].valid <= 1'b0;
                buffer[i].done  <= 1'b0;
            end
            tail_ptr <= '0;
            send_ptr <= '0;
            head_ptr <= '0;
        end else begin
            if (buffer[head_ptr].valid && buffer[head_ptr].done) begin
                buffer[head_ptr].valid <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
            for (int i = 0; i < `ICACHE_SEND_SIZE; i++) begin
                if (match[i]) begin
                    buffer[i].done <= 1'b1;
                end
            end
            if (accept) begin
                buffer[send_ptr].mem_tag <= mem_response;
                send_ptr <= send_ptr + 1'b1;
            end
            // new miss overrides a retire of the same slot
            if (enqueue) begin
                buffer[tail_ptr] <= '{valid: 1'b1, done: 1'b0, mem_tag: 4'h0,
                                      addr: probe.addr};
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    // loads carry whole block addresses
    load_from_live_entry: assert property (@(posedge clock) disable iff (reset)
        (mem_command == icache_pkg::BUS_LOAD) |->
            buffer[send_ptr].valid && (mem_addr[2:0] == 3'b000))
        else $error("load issued from slot %0d at unaligned address %h", send_ptr, mem_addr);

    // a refused load stays on the bus with the same address
    refused_load_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command == icache_pkg::BUS_LOAD) && (mem_response == 4'h0) && !redirect
        |=> (mem_command == icache_pkg::BUS_LOAD) && $stable(mem_addr))
        else $error("refused load dropped at address %h", $past(mem_addr));

endmodule

/* cache_store.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module cache_store (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`ICACHE_XLEN-1:0] proc_addr,
    input  icache_pkg::probe_t      probe,
    input  icache_pkg::fill_t       fill,
    output logic [`ICACHE_XLEN-1:0] proc_data,
    output logic                    fetch_hit,
    output logic                    probe_hit
);

    localparam int IDX_W = $clog2(`ICACHE_LINES);

    icache_pkg::icache_line_t                               lines [`ICACHE_LINES];
    icache_pkg::victim_line_t [`ICACHE_VICTIM_WAYS-1:0]     victim;
    logic                                                   lru;  // next victim way to replace

    logic [IDX_W-1:0]          fetch_idx;
    icache_pkg::icache_line_t  fetch_line;
    logic                      fetch_line_hit;
    logic                      fetch_vhit;
    logic                      fetch_way;
    logic [63:0]               fetch_block;

    logic [IDX_W-1:0]          probe_idx;
    icache_pkg::icache_line_t  probe_line;
    logic                      probe_line_hit;
    logic                      probe_vhit;
    logic                      probe_way;
    logic                      swap_en;

    logic [IDX_W-1:0]          fill_idx;
    icache_pkg::icache_line_t  fill_line;

    // searches the victim entries for a block, result is {hit, way}
    function automatic logic [1:0] victim_find(
        input icache_pkg::victim_line_t [`ICACHE_VICTIM_WAYS-1:0] ways,
        input logic [12:0]                                        blk
    );
        logic [1:0] found;
        found = 2'b00;
        for (int i = 0; i < `ICACHE_VICTIM_WAYS; i++) begin
            if (ways[i].valid && (ways[i].tag == blk)) begin
                found = {1'b1, 1'(i)};
            end
        end
        return found;
    endfunction

    // fetch side lookup
    assign fetch_idx      = proc_addr[7:3];
    assign fetch_line     = lines[fetch_idx];
    assign fetch_line_hit = fetch_line.valid && (fetch_line.tag == proc_addr[15:8]);
    assign {fetch_vhit, fetch_way} = victim_find(victim, proc_addr[15:3]);
    assign fetch_hit      = fetch_line_hit || fetch_vhit;
    assign fetch_block    = fetch_line_hit ? fetch_line.data : victim[fetch_way].data;
    assign proc_data      = proc_addr[2] ? fetch_block[63:32] : fetch_block[31:0];

    // probe side lookup
    assign probe_idx      = probe.addr[7:3];
    assign probe_line     = lines[probe_idx];
    assign probe_line_hit = probe_line.valid && (probe_line.tag == probe.addr[15:8]);
    assign {probe_vhit, probe_way} = victim_find(victim, probe.addr[15:3]);
    assign probe_hit      = probe.valid && (probe_line_hit || probe_vhit);
    assign swap_en        = probe.valid && probe_vhit && !probe_line_hit;

    assign fill_idx  = fill.addr[7:3];
    assign fill_line = lines[fill_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
            for (int i = 0; i < `ICACHE_VICTIM_WAYS; i++) begin
                victim[i].valid <= 1'b0;
            end
            lru <= 1'b0;
        end else begin
            if (swap_en) begin
                // victim block moves home, indexed line takes its place
                lines[probe_idx] <= '{valid: 1'b1,
                                      tag:   probe.addr[15:8],
                                      data:  victim[probe_way].data};
                victim[probe_way] <= '{valid: probe_line.valid,
                                       tag:   {probe_line.tag, probe_idx},
                                       data:  probe_line.data};
                lru <= ~probe_way;
            end
            // fill wins the victim slot and lru if both land this cycle
            if (fill.valid) begin
                victim[lru] <= '{valid: fill_line.valid,
                                 tag:   {fill_line.tag, fill_idx},
                                 data:  fill_line.data};
                lines[fill_idx] <= '{valid: 1'b1,
                                     tag:   fill.addr[15:8],
                                     data:  fill.data};
                lru <= ~lru;
            end
        end
    end

    // prefetch probes and returning fills stay on different lines
    swap_fill_apart: assert property (@(posedge clock) disable iff (reset)
        !(swap_en && fill.valid && (fill_idx == probe_idx)))
        else $error("victim swap and fill both target index %0d", probe_idx);

endmodule

/* prefetch_ctrl.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module prefetch_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`ICACHE_XLEN-1:0] proc_addr,
    input  logic                    fetch_hit,
    output icache_pkg::probe_t      probe,
    output logic                    redirect
);

    logic [`ICACHE_XLEN-1:0] last_addr;
    logic [`ICACHE_XLEN-1:0] probe_addr;
    logic [`ICACHE_XLEN-1:0] fetch_block;
    logic [`ICACHE_XLEN-1:0] window_end;
    logic                    running;    // low in the first cycle out of reset
    logic                    in_window;

    assign fetch_block = {proc_addr[`ICACHE_XLEN-1:3], 3'b000};
    assign window_end  = fetch_block + (`ICACHE_PREFETCH_BLOCKS * 8);
    assign in_window   = (probe_addr <= window_end);

    // anything but the same word or the next word starts a new stream
    assign redirect = !running ||
                      ((proc_addr != last_addr) && (proc_addr != last_addr + 4));

    assign probe.valid = running && in_window;
    assign probe.addr  = probe_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            running    <= 1'b0;
            last_addr  <= '0;
            probe_addr <= '0;
        end else begin
            running   <= 1'b1;
            last_addr <= proc_addr;
            if (redirect) begin
                // skip the fetch block when it is already present
                if (fetch_hit) begin
                    probe_addr <= fetch_block + 8;
                end else begin
                    probe_addr <= fetch_block;
                end
            end else if (in_window) begin
                probe_addr <= probe_addr + 8;   // one block per cycle
            end
        end
    end

endmodule

/* icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_command_e;

    typedef struct packed {
        logic        valid;
        logic [7:0]  tag;     // addr[15:8]
        logic [63:0] data;
    } icache_line_t;

    typedef struct packed {
        logic        valid;
        logic [12:0] tag;     // addr[15:3], line tag plus index
        logic [63:0] data;
    } victim_line_t;

    typedef struct packed {
        logic                    valid;
        logic                    done;     // block has come back
        logic [3:0]              mem_tag;  // zero until memory accepts
        logic [`ICACHE_XLEN-1:0] addr;
    } send_entry_t;

    typedef struct packed {
        logic                    valid;
        logic [`ICACHE_XLEN-1:0] addr;     // block aligned
    } probe_t;

    typedef struct packed {
        logic                    valid;
        logic [`ICACHE_XLEN-1:0] addr;
        logic [63:0]             data;
    } fill_t;

endpackage

/* icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// address and instruction word width
`define ICACHE_XLEN 32

// main array, 8-byte lines
`define ICACHE_LINES 32

// fully associative victim entries, one lru bit
`define ICACHE_VICTIM_WAYS 2

// outstanding memory requests
`define ICACHE_SEND_SIZE 4
`define ICACHE_SEND_LEN 2   // log2 of send size

// how far the walker runs ahead of the fetch block
`define ICACHE_PREFETCH_BLOCKS 7

`endif
